/* hw/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data and address width
`define RV_XLEN 32

// Architectural integer registers
`define RV_NREGS 32

// Bubble word, addi x0,x0,0
`define RV_NOP 32'h0000_0013

`endif

/* hw/rv_pkg.sv */
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

    // Major opcodes of the supported classes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Zero is none, so a cleared stage writes nothing back
    typedef enum logic [1:0] {
        RES_NONE = 2'd0,
        RES_ALU  = 2'd1,
        RES_LINK = 2'd2
    } res_src_e;

    // Zero is never, so a cleared stage cannot redirect
    typedef enum logic [2:0] {
        BR_NEVER  = 3'd0,
        BR_ALWAYS = 3'd1,
        BR_EQ     = 3'd2,
        BR_NE     = 3'd3,
        BR_LT     = 3'd4,
        BR_GE     = 3'd5,
        BR_LTU    = 3'd6,
        BR_GEU    = 3'd7
    } br_cond_e;

    typedef struct packed {
        logic                reg_write;
        alu_op_e             alu_op;
        logic                alu_a_pc;
        logic                alu_b_imm;
        res_src_e            res_src;
        br_cond_e            br_cond;
        logic                jalr;
        logic [31:0]         instr;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
        logic [`RV_XLEN-1:0] imm;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] pc_plus4;
    } id_ex_t;

    typedef struct packed {
        logic                reg_write;
        logic [4:0]          rd;
        res_src_e            res_src;
        logic [`RV_XLEN-1:0] alu_result;
        logic [`RV_XLEN-1:0] pc_plus4;
    } ex_wb_t;

    // Register file write port
    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

/* hw/rv_decode.sv */
`default_nettype none

`include "rv_params.svh"

module rv_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  logic [31:0]         instr,
    input  logic                redirect,
    input  logic [`RV_XLEN-1:0] redirect_pc,
    input  rv_pkg::wb_t         wb,
    output rv_pkg::id_ex_t      id
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic                known;
    logic [31:0]         word;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [2:0]          funct3;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    // sub selects SUB for funct3 000, sra selects SRA for funct3 101
    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic sub,
                                                input logic sra);
        case (f3)
            3'b000:  return sub ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return sra ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        case (instr[6:0])
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC, rv_pkg::OPC_JAL, rv_pkg::OPC_JALR,
            rv_pkg::OPC_BRANCH, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    // Bubbles and unknown opcodes decode as the NOP word
    assign word   = (instr_valid && known) ? instr : `RV_NOP;
    assign rs1    = word[19:15];
    assign rs2    = word[24:20];
    assign funct3 = word[14:12];

    assign imm_i = `RV_XLEN'(signed'(word[31:20]));
    assign imm_b = `RV_XLEN'(signed'({word[31], word[7], word[30:25], word[11:8], 1'b0}));
    assign imm_u = `RV_XLEN'(signed'({word[31:12], 12'b0}));
    assign imm_j = `RV_XLEN'(signed'({word[31], word[19:12], word[20], word[30:21], 1'b0}));

    // Write-through read, x0 reads zero
    always_comb begin
        if (rs1 == 5'd0) rs1_data = '0;
        else if (wb.valid && wb.rd == rs1) rs1_data = wb.data;
        else rs1_data = regs[rs1];

        if (rs2 == 5'd0) rs2_data = '0;
        else if (wb.valid && wb.rd == rs2) rs2_data = wb.data;
        else rs2_data = regs[rs2];
    end

    assign pc_plus4 = pc + `RV_XLEN'(4);

    always_comb begin
        id           = '0;
        id.alu_op    = rv_pkg::ALU_ADD;
        id.res_src   = rv_pkg::RES_NONE;
        id.br_cond   = rv_pkg::BR_NEVER;
        id.instr     = word;
        id.rd        = word[11:7];
        id.rs1       = rs1;
        id.rs2       = rs2;
        id.rs1_data  = rs1_data;
        id.rs2_data  = rs2_data;
        id.imm       = imm_i;
        id.pc        = pc;
        id.pc_plus4  = pc_plus4;

        case (rv_pkg::rv_opcode_e'(word[6:0]))
            rv_pkg::OPC_LUI: begin
                id.reg_write = 1'b1;
                id.alu_op    = rv_pkg::ALU_PASS_B;
                id.alu_b_imm = 1'b1;
                id.res_src   = rv_pkg::RES_ALU;
                id.imm       = imm_u;
            end
            rv_pkg::OPC_AUIPC: begin
                id.reg_write = 1'b1;
                id.alu_a_pc  = 1'b1;
                id.alu_b_imm = 1'b1;
                id.res_src   = rv_pkg::RES_ALU;
                id.imm       = imm_u;
            end
            rv_pkg::OPC_JAL: begin
                id.reg_write = 1'b1;
                id.res_src   = rv_pkg::RES_LINK;
                id.br_cond   = rv_pkg::BR_ALWAYS;
                id.imm       = imm_j;
            end
            rv_pkg::OPC_JALR: begin
                id.reg_write = 1'b1;
                id.res_src   = rv_pkg::RES_LINK;
                id.br_cond   = rv_pkg::BR_ALWAYS;
                id.jalr      = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                id.imm = imm_b;
                case (funct3)
                    3'b000:  id.br_cond = rv_pkg::BR_EQ;
                    3'b001:  id.br_cond = rv_pkg::BR_NE;
                    3'b100:  id.br_cond = rv_pkg::BR_LT;
                    3'b101:  id.br_cond = rv_pkg::BR_GE;
                    3'b110:  id.br_cond = rv_pkg::BR_LTU;
                    3'b111:  id.br_cond = rv_pkg::BR_GEU;
                    default: id.br_cond = rv_pkg::BR_NEVER;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                id.reg_write = 1'b1;
                id.alu_op    = alu_sel(funct3, 1'b0, word[30]);
                id.alu_b_imm = 1'b1;
                id.res_src   = rv_pkg::RES_ALU;
            end
            rv_pkg::OPC_OP: begin
                id.reg_write = 1'b1;
                id.alu_op    = alu_sel(funct3, word[30], word[30]);
                id.res_src   = rv_pkg::RES_ALU;
            end
            default: ;
        endcase
    end

    // The discarded slot on redirect does not advance the pc
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (instr_valid) begin
            pc <= pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (wb.valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

`default_nettype wire

/* hw/rv_id_ex_reg.sv */
`default_nettype none

`include "rv_params.svh"

module rv_id_ex_reg (
    input  logic           clk,
    input  logic           rst,
    input  logic           flush,
    input  rv_pkg::id_ex_t id,
    output rv_pkg::id_ex_t ex
);

    // A taken branch in execute kills the instruction now in decode
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ex         <= '0;
            ex.alu_op  <= rv_pkg::ALU_ADD;
            ex.res_src <= rv_pkg::RES_NONE;
            ex.br_cond <= rv_pkg::BR_NEVER;
            ex.instr   <= `RV_NOP;
        end else begin
            ex <= id;
        end
    end

endmodule

`default_nettype wire

/* hw/rv_execute.sv */
`default_nettype none

`include "rv_params.svh"

module rv_execute (
    input  rv_pkg::id_ex_t      ex,
    input  rv_pkg::wb_t         wb,
    output logic                branch_taken,
    output logic [`RV_XLEN-1:0] branch_target,
    output rv_pkg::ex_wb_t      ex_wb
);

    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] target_base;
    logic [`RV_XLEN-1:0] target_sum;

    // Forward from the instruction one ahead, now in write-back
    assign rs1_val = (wb.valid && wb.rd == ex.rs1) ? wb.data : ex.rs1_data;
    assign rs2_val = (wb.valid && wb.rd == ex.rs2) ? wb.data : ex.rs2_data;

    assign op_a  = ex.alu_a_pc ? ex.pc : rs1_val;
    assign op_b  = ex.alu_b_imm ? ex.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex.alu_op)
            rv_pkg::ALU_ADD:    alu_result = op_a + op_b;
            rv_pkg::ALU_SUB:    alu_result = op_a - op_b;
            rv_pkg::ALU_SLL:    alu_result = op_a << shamt;
            rv_pkg::ALU_SLT:    alu_result = `RV_XLEN'($signed(op_a) < $signed(op_b));
            rv_pkg::ALU_SLTU:   alu_result = `RV_XLEN'(op_a < op_b);
            rv_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
            rv_pkg::ALU_SRL:    alu_result = op_a >> shamt;
            rv_pkg::ALU_SRA:    alu_result = `RV_XLEN'($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:     alu_result = op_a | op_b;
            rv_pkg::ALU_AND:    alu_result = op_a & op_b;
            rv_pkg::ALU_PASS_B: alu_result = op_b;
            default:            alu_result = op_a + op_b;
        endcase
    end

    // Conditions compare the forwarded register values
    always_comb begin
        case (ex.br_cond)
            rv_pkg::BR_ALWAYS: branch_taken = 1'b1;
            rv_pkg::BR_EQ:     branch_taken = (rs1_val == rs2_val);
            rv_pkg::BR_NE:     branch_taken = (rs1_val != rs2_val);
            rv_pkg::BR_LT:     branch_taken = ($signed(rs1_val) < $signed(rs2_val));
            rv_pkg::BR_GE:     branch_taken = ($signed(rs1_val) >= $signed(rs2_val));
            rv_pkg::BR_LTU:    branch_taken = (rs1_val < rs2_val);
            rv_pkg::BR_GEU:    branch_taken = (rs1_val >= rs2_val);
            default:           branch_taken = 1'b0;
        endcase
    end

    // JALR clears bit 0 of rs1 plus offset
    assign target_base   = ex.jalr ? rs1_val : ex.pc;
    assign target_sum    = target_base + ex.imm;
    assign branch_target = {target_sum[`RV_XLEN-1:1], target_sum[0] & ~ex.jalr};

    always_comb begin
        ex_wb.reg_write  = ex.reg_write;
        ex_wb.rd         = ex.rd;
        ex_wb.res_src    = ex.res_src;
        ex_wb.alu_result = alu_result;
        ex_wb.pc_plus4   = ex.pc_plus4;
    end

endmodule

`default_nettype wire

/* hw/rv_result.sv */
`default_nettype none

`include "rv_params.svh"

module rv_result (
    input  logic           clk,
    input  logic           rst,
    input  rv_pkg::ex_wb_t ex_wb,
    output rv_pkg::wb_t    wb
);

    rv_pkg::ex_wb_t wb_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q.reg_write <= 1'b0;
        end else begin
            wb_q.reg_write <= ex_wb.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_q.rd         <= ex_wb.rd;
        wb_q.res_src    <= ex_wb.res_src;
        wb_q.alu_result <= ex_wb.alu_result;
        wb_q.pc_plus4   <= ex_wb.pc_plus4;
    end

    // x0 is never written
    assign wb.valid = wb_q.reg_write && (wb_q.rd != 5'd0);
    assign wb.rd    = wb_q.rd;

    // Jumps write back the link address
    assign wb.data = (wb_q.res_src == rv_pkg::RES_LINK) ? wb_q.pc_plus4 : wb_q.alu_result;

endmodule

`default_nettype wire

/* hw/rv_int_pipe.sv */
`default_nettype none

`include "rv_params.svh"

module rv_int_pipe (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  logic [31:0]         instr,
    output logic                branch_taken,
    output logic [`RV_XLEN-1:0] branch_target,
    output logic                wb_valid,
    output logic [4:0]          wb_rd,
    output logic [`RV_XLEN-1:0] wb_data
);

    rv_pkg::id_ex_t id;
    rv_pkg::id_ex_t ex;
    rv_pkg::ex_wb_t ex_wb;
    rv_pkg::wb_t    wb;

    rv_decode rv_decode_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .redirect    (branch_taken),
        .redirect_pc (branch_target),
        .wb          (wb),
        .id          (id)
    );

    rv_id_ex_reg rv_id_ex_reg_i (
        .clk   (clk),
        .rst   (rst),
        .flush (branch_taken),
        .id    (id),
        .ex    (ex)
    );

    rv_execute rv_execute_i (
        .ex            (ex),
        .wb            (wb),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .ex_wb         (ex_wb)
    );

    rv_result rv_result_i (
        .clk   (clk),
        .rst   (rst),
        .ex_wb (ex_wb),
        .wb    (wb)
    );

    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

`default_nettype wire

/* test/rv_int_pipe_check.sv */
`default_nettype none

`include "rv_params.svh"

module rv_int_pipe_check (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  logic [31:0]         instr,
    input  logic                branch_taken,
    input  logic [`RV_XLEN-1:0] branch_target,
    input  logic                wb_valid,
    input  logic [4:0]          wb_rd,
    input  logic [`RV_XLEN-1:0] wb_data,
    output int                  errors,
    output int                  checks,
    output int                  pending
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] val;
        logic        taken;
        logic [31:0] target;
        logic [31:0] next_pc;
    } ref_t;

    typedef struct packed {
        logic [31:0] due;
        logic [4:0]  rd;
        logic [31:0] data;
    } ev_t;

    logic [31:0] regs [`RV_NREGS];
    logic [31:0] pc;
    logic        squash;
    int          cyc;
    ev_t         wb_q [$];
    ev_t         br_q [$];

    function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Architectural effect of one instruction
    function automatic ref_t ref_step(input logic [31:0] w, input logic [31:0] cur_pc,
                                      input logic [31:0] a, input logic [31:0] b);
        ref_t        r;
        logic [2:0]  f3;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        f3    = w[14:12];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'b0};
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        r     = '0;
        r.rd  = w[11:7];
        case (w[6:0])
            7'h37: begin
                r.we  = 1'b1;
                r.val = imm_u;
            end
            7'h17: begin
                r.we  = 1'b1;
                r.val = cur_pc + imm_u;
            end
            7'h6f: begin
                r.we     = 1'b1;
                r.val    = cur_pc + 32'd4;
                r.taken  = 1'b1;
                r.target = cur_pc + imm_j;
            end
            7'h67: begin
                r.we     = 1'b1;
                r.val    = cur_pc + 32'd4;
                r.taken  = 1'b1;
                r.target = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                r.target = cur_pc + imm_b;
                case (f3)
                    3'b000:  r.taken = (a == b);
                    3'b001:  r.taken = (a != b);
                    3'b100:  r.taken = ($signed(a) < $signed(b));
                    3'b101:  r.taken = ($signed(a) >= $signed(b));
                    3'b110:  r.taken = (a < b);
                    3'b111:  r.taken = (a >= b);
                    default: r.taken = 1'b0;
                endcase
            end
            7'h13: begin
                r.we  = 1'b1;
                r.val = alu_calc(f3, f3 == 3'b101 && w[30], a, imm_i);
            end
            7'h33: begin
                r.we  = 1'b1;
                r.val = alu_calc(f3, w[30], a, b);
            end
            default: ;
        endcase
        r.we      = r.we && (r.rd != 5'd0);
        r.next_pc = r.taken ? r.target : cur_pc + 32'd4;
        return r;
    endfunction

    initial begin
        errors  = 0;
        checks  = 0;
        pending = 0;
    end

    always @(posedge clk) begin
        ref_t r;
        ev_t  e;
        if (rst) begin
            pc     = '0;
            squash = 1'b0;
            cyc    = 0;
            wb_q.delete();
            br_q.delete();
            for (int i = 0; i < `RV_NREGS; i++) regs[i] = '0;
        end else begin
            cyc = cyc + 1;

            // Branch side
            if (branch_taken === 1'b1) begin
                checks = checks + 1;
                if (br_q.size() == 0) begin
                    $display("branch_taken raised at cycle %0d with no branch expected", cyc);
                    errors = errors + 1;
                end else begin
                    e = br_q.pop_front();
                    if (e.due != 32'(cyc)) begin
                        $display("branch arrived at cycle %0d, expected at %0d", cyc, e.due);
                        errors = errors + 1;
                    end
                    if (branch_target !== e.data) begin
                        $display("error branch_target got %h expected %h", branch_target, e.data);
                        errors = errors + 1;
                    end
                end
            end else if (branch_taken !== 1'b0) begin
                $display("branch_taken is unknown at cycle %0d", cyc);
                errors = errors + 1;
            end else if (br_q.size() != 0 && br_q[0].due <= 32'(cyc)) begin
                e = br_q.pop_front();
                $display("branch expected at cycle %0d never arrived", e.due);
                errors = errors + 1;
            end

            // Write-back side
            if (wb_valid === 1'b1) begin
                checks = checks + 1;
                if (wb_q.size() == 0) begin
                    $display("wb_valid raised at cycle %0d with no write-back expected", cyc);
                    errors = errors + 1;
                end else begin
                    e = wb_q.pop_front();
                    if (e.due != 32'(cyc)) begin
                        $display("write-back arrived at cycle %0d, expected at %0d", cyc, e.due);
                        errors = errors + 1;
                    end
                    if (wb_rd !== e.rd) begin
                        $display("error wb_rd got %h expected %h", wb_rd, e.rd);
                        errors = errors + 1;
                    end
                    if (wb_data !== e.data) begin
                        $display("error wb_data got %h expected %h", wb_data, e.data);
                        errors = errors + 1;
                    end
                end
            end else if (wb_valid !== 1'b0) begin
                $display("wb_valid is unknown at cycle %0d", cyc);
                errors = errors + 1;
            end else if (wb_q.size() != 0 && wb_q[0].due <= 32'(cyc)) begin
                e = wb_q.pop_front();
                $display("write-back to x%0d expected at cycle %0d never arrived", e.rd, e.due);
                errors = errors + 1;
            end

            // The slot right after a taken branch is dropped, valid or not
            if (squash) begin
                squash = 1'b0;
            end else if (instr_valid) begin
                r = ref_step(instr, pc, regs[instr[19:15]], regs[instr[24:20]]);
                if (r.we) begin
                    regs[r.rd] = r.val;
                    wb_q.push_back('{due: 32'(cyc + 2), rd: r.rd, data: r.val});
                end
                if (r.taken) begin
                    br_q.push_back('{due: 32'(cyc + 1), rd: 5'd0, data: r.target});
                    squash = 1'b1;
                end
                pc = r.next_pc;
            end
            pending = wb_q.size() + br_q.size();
        end
    end

endmodule

`default_nettype wire

/* test/rv_int_pipe_tb.sv */
`default_nettype none

`include "rv_params.svh"

module rv_int_pipe_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_RANDOM = 300;
    localparam int MARGIN   = 24;

    localparam logic [6:0] OPC_LUI    = 7'h37;
    localparam logic [6:0] OPC_AUIPC  = 7'h17;
    localparam logic [6:0] OPC_JALR   = 7'h67;
    localparam logic [6:0] OPC_OP_IMM = 7'h13;

    logic                clk;
    logic                rst;
    logic                instr_valid;
    logic [31:0]         instr;
    logic                branch_taken;
    logic [`RV_XLEN-1:0] branch_target;
    logic                wb_valid;
    logic [4:0]          wb_rd;
    logic [`RV_XLEN-1:0] wb_data;

    int          errors;
    int          checks;
    int          pending;
    int          cycles;
    int          limit;
    integer      seed;
    logic [32:0] stream [$];

    initial clk = 1'b0;
    always #10 clk = ~clk;

    rv_int_pipe rv_int_pipe_i (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    rv_int_pipe_check rv_int_pipe_check_i (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .errors        (errors),
        .checks        (checks),
        .pending       (pending)
    );

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // Mostly x1..x4 so that dependences are close together
    function automatic logic [4:0] pick_src();
        logic [31:0] r;
        r = rnd();
        if (r[1:0] == 2'd0) return 5'd1 + 5'(r[9:2] % 8'd31);
        return 5'd1 + 5'(r[3:2]);
    endfunction

    function automatic logic [4:0] pick_dst();
        logic [31:0] r;
        r = rnd();
        if (r[3:0] == 4'd0) return 5'd0;
        return pick_src();
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // Random bubble before some instructions
    task automatic add_instr(input logic [31:0] w);
        logic [31:0] r;
        r = rnd();
        if (r[2:0] == 3'd0) stream.push_back({1'b0, rnd()});
        stream.push_back({1'b1, w});
    endtask

    task automatic gen_stream();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  t;
        // The register file has no reset, so every register gets a value first
        for (int i = 1; i < `RV_NREGS; i++) begin
            a = rnd();
            stream.push_back({1'b1, enc_i(a[31:20], 5'd0, 3'd0, 5'(i), OPC_OP_IMM)});
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            a  = rnd();
            b  = rnd();
            f3 = a[6:4];
            case (a[3:0])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
                    if (f3 == 3'b001) imm = {7'b0, a[20:16]};
                    else if (f3 == 3'b101) imm = {1'b0, a[7], 5'b0, a[20:16]};
                    else imm = a[31:20];
                    add_instr(enc_i(imm, pick_src(), f3, pick_dst(), OPC_OP_IMM));
                end
                4'd6, 4'd7, 4'd8, 4'd9: begin
                    add_instr(enc_r(((f3 == 3'b000 || f3 == 3'b101) && a[7]) ? 7'h20 : 7'h00,
                                    pick_src(), pick_src(), f3, pick_dst()));
                end
                4'd10, 4'd11: begin
                    if (f3 == 3'b010 || f3 == 3'b011) f3 = {1'b1, f3[1:0]};
                    add_instr(enc_b({{8{a[12]}}, a[11:9], 2'b0}, pick_src(), pick_src(), f3));
                end
                4'd12: add_instr({b[31:12], pick_dst(), OPC_LUI});
                4'd13: add_instr({b[31:12], pick_dst(), OPC_AUIPC});
                4'd14: add_instr(enc_j({{15{a[12]}}, a[11:8], 2'b0}, pick_dst()));
                default: begin
                    t = pick_src();
                    add_instr({12'b0, b[19:12], t, OPC_LUI});
                    add_instr(enc_i(b[11:0], t, 3'd0, t, OPC_OP_IMM));
                    add_instr(enc_i({{7{a[20]}}, a[19:15]}, t, 3'd0, pick_dst(), OPC_JALR));
                end
            endcase
        end
    endtask

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = `RV_NOP;
        seed        = 32'h0cef_9aa9;
        gen_stream();
        limit = stream.size() + 2 + MARGIN;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < stream.size(); i++) begin
            {instr_valid, instr} <= stream[i];
            @(posedge clk);
        end
        instr_valid <= 1'b0;
        instr       <= `RV_NOP;
        @(negedge clk);
        while (pending != 0) @(negedge clk);
        // A few idle cycles catch stray write-backs or branches
        repeat (4) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial cycles = 0;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles with %0d events outstanding", cycles, pending);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_id_ex_reg.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_int_pipe.sv
test/rv_int_pipe_check.sv
test/rv_int_pipe_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing -f list.f --top-module rv_int_pipe_tb -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
